/* include/mcpu_settings.svh */
// opcode encodings, condition-code bit positions and program counter reset value
`ifndef MCPU_SETTINGS_SVH
`define MCPU_SETTINGS_SVH

// single-byte opcodes
`define MCPU_OP_NOP      8'h12
`define MCPU_OP_LDA      8'h86
`define MCPU_OP_LDB      8'hC6
`define MCPU_OP_LDD      8'hCC
`define MCPU_OP_LDX      8'h8E
`define MCPU_OP_JMP      8'h7E
`define MCPU_OP_PSHS     8'h34
`define MCPU_OP_PULS     8'h35

// high nibble of the relative branch rows
`define MCPU_OP_BCC_ROW  4'h2
`define MCPU_OP_LBCC_ROW 4'h5

// flag positions inside the cc byte
`define MCPU_CC_C        0
`define MCPU_CC_V        1
`define MCPU_CC_Z        2
`define MCPU_CC_N        3

`define MCPU_RESET_PC    16'h0000

`endif

/* src/mcpu_pkg.sv */
// shared types: condition codes, microcode word and register-update strobes
package mcpu_pkg;

    // same bit order as the 6809 cc register, e in the msb
    typedef struct packed {
        logic e;
        logic f;
        logic h;
        logic i;
        logic n;
        logic z;
        logic v;
        logic c;
    } cc_t;

    // strobes issued for one micro-step
    typedef struct packed {
        logic opd;
        logic ld8;
        logic ld16;
        logic br8;
        logic br16;
        logic jmp;
        logic stk_go;
        // hold the step while the stack unit is busy
        logic stk_wait;
        // back to fetch after this step
        logic last;
    } uc_word_t;

    typedef struct packed {
        logic a;
        logic b;
        logic d;
        logic x;
    } reg_upd_t;

endpackage

/* src/mcpu_branch.sv */
// branch condition evaluator for the short and long relative branches
`include "mcpu_settings.svh"

module mcpu_branch (
    input  logic [7:0]     op_q,
    input  mcpu_pkg::cc_t  cc,
    output logic           taken
);
    logic [7:0] ccb;
    logic       flag_c;
    logic       flag_v;
    logic       flag_z;
    logic       flag_n;
    logic       base;

    assign ccb    = cc;
    assign flag_c = ccb[`MCPU_CC_C];
    assign flag_v = ccb[`MCPU_CC_V];
    assign flag_z = ccb[`MCPU_CC_Z];
    assign flag_n = ccb[`MCPU_CC_N];

    // even conditions only, odd ones are their complement
    always_comb begin
        case (op_q[3:1])
            3'd0:    base = 1'b1;
            3'd1:    base = ~(flag_c | flag_z);
            3'd2:    base = ~flag_c;
            3'd3:    base = ~flag_z;
            3'd4:    base = ~flag_v;
            3'd5:    base = ~flag_n;
            3'd6:    base = ~(flag_n ^ flag_v);
            default: base = ~(flag_z | (flag_n ^ flag_v));
        endcase
    end

    // bit 0 flips always/never, hi/ls, cc/cs and so on
    assign taken = base ^ op_q[0];

endmodule

/* src/mcpu_pshpul.sv */
// push/pull sequencer: walks the postbyte one register byte per cycle
module mcpu_pshpul (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       stk_go,
    input  logic       stk_pull,
    input  logic [7:0] postbyte,
    output logic [7:0] psh_sel,
    output logic       hihalf,
    output logic       pul_en,
    output logic       psh_dec,
    output logic       wrq,
    output logic       stack_busy
);
    // registers still to be transferred
    logic [7:0] pend;
    logic       pull;
    // second byte of a 16-bit register
    logic       half;
    logic [7:0] lo_sel;
    logic [7:0] hi_sel;
    logic       is16;
    logic       xfer;

    // lowest pending bit for pulls
    assign lo_sel = pend & (~pend + 8'd1);

    // highest pending bit for pushes
    always_comb begin
        hi_sel = '0;
        for (int i = 0; i < 8; i++) begin
            if (pend[i]) begin
                hi_sel = 8'd1 << i;
            end
        end
    end

    assign psh_sel    = pull ? lo_sel : hi_sel;
    assign stack_busy = |pend;

    // pc, u/s, y and x sit in bits 7 to 4
    assign is16 = |psh_sel[7:4];

    // push writes low byte first, pull reads high byte first
    assign hihalf = is16 & (pull ^ half);

    assign xfer    = cen & stack_busy;
    assign wrq     = xfer & ~pull;
    assign psh_dec = xfer & ~pull;
    assign pul_en  = xfer & pull;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= '0;
            pull <= 1'b0;
            half <= 1'b0;
        end else if (cen) begin
            if (stk_go) begin
                pend <= postbyte;
                pull <= stk_pull;
                half <= 1'b0;
            end else if (stack_busy) begin
                if (is16 && !half) begin
                    half <= 1'b1;
                end else begin
                    // register done, drop its bit
                    half <= 1'b0;
                    pend <= pend & ~psh_sel;
                end
            end
        end
    end

endmodule

/* src/mcpu_ucode.sv */
// opcode sequencer: fetch latch, step counter and microcode table
`include "mcpu_settings.svh"

module mcpu_ucode (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          op,
    input  logic                stack_busy,
    output mcpu_pkg::uc_word_t  uc,
    output logic                fetch,
    output logic [7:0]          op_q,
    output logic                stk_pull
);
    import mcpu_pkg::*;

    typedef enum logic [2:0] {
        CL_NOP,
        CL_LD8,
        CL_LD16,
        CL_BR8,
        CL_BR16,
        CL_JMP,
        CL_STK
    } op_class_e;

    logic      in_fetch;
    logic [1:0] step;
    op_class_e cls;
    uc_word_t  uc_raw;

    function automatic op_class_e op_class(input logic [7:0] o);
        op_class_e c;
        c = CL_NOP;
        case (o)
            `MCPU_OP_LDA, `MCPU_OP_LDB:   c = CL_LD8;
            `MCPU_OP_LDD, `MCPU_OP_LDX:   c = CL_LD16;
            `MCPU_OP_JMP:                 c = CL_JMP;
            `MCPU_OP_PSHS, `MCPU_OP_PULS: c = CL_STK;
            default: begin
                if (o[7:4] == `MCPU_OP_BCC_ROW) begin
                    c = CL_BR8;
                end else if (o[7:4] == `MCPU_OP_LBCC_ROW) begin
                    c = CL_BR16;
                end
            end
        endcase
        return c;
    endfunction

    assign cls      = op_class(op_q);
    assign stk_pull = (op_q == `MCPU_OP_PULS);

    // microcode table, all zero while fetching
    always_comb begin
        uc_raw = '0;
        if (!in_fetch) begin
            case (cls)
                CL_LD8: begin
                    uc_raw.opd  = 1'b1;
                    uc_raw.ld8  = 1'b1;
                    uc_raw.last = 1'b1;
                end
                CL_LD16: begin
                    uc_raw.opd  = 1'b1;
                    uc_raw.ld16 = (step == 2'd1);
                    uc_raw.last = (step == 2'd1);
                end
                CL_BR8: begin
                    uc_raw.opd  = (step == 2'd0);
                    uc_raw.br8  = (step == 2'd1);
                    uc_raw.last = (step == 2'd1);
                end
                CL_BR16: begin
                    uc_raw.opd  = (step != 2'd2);
                    uc_raw.br16 = (step == 2'd2);
                    uc_raw.last = (step == 2'd2);
                end
                CL_JMP: begin
                    uc_raw.opd  = (step != 2'd2);
                    uc_raw.jmp  = (step == 2'd2);
                    uc_raw.last = (step == 2'd2);
                end
                CL_STK: begin
                    // postbyte, then wait for the transfers to drain
                    uc_raw.opd      = (step == 2'd0);
                    uc_raw.stk_go   = (step == 2'd0);
                    uc_raw.stk_wait = (step == 2'd1);
                    uc_raw.last     = (step == 2'd1);
                end
                default: uc_raw.last = 1'b1;
            endcase
        end
    end

    // strobes only in enabled cycles
    assign uc    = cen ? uc_raw : '0;
    assign fetch = cen & in_fetch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_fetch <= 1'b1;
            step     <= '0;
            op_q     <= `MCPU_OP_NOP;
        end else if (cen) begin
            if (in_fetch) begin
                op_q     <= op;
                step     <= '0;
                // single-cycle opcodes stay in fetch
                in_fetch <= (op_class(op) == CL_NOP);
            end else if (uc_raw.stk_wait && stack_busy) begin
                step <= step;
            end else if (uc_raw.last) begin
                in_fetch <= 1'b1;
            end else begin
                step <= step + 2'd1;
            end
        end
    end

endmodule

/* src/mcpu_ctrl.sv */
// control top: program counter, register-update decode, sequencer, branch and stack units
`include "mcpu_settings.svh"

module mcpu_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          op,
    input  logic [15:0]         mdata,
    input  mcpu_pkg::cc_t       cc,
    input  logic                mem_busy,
    output logic [15:0]         pc,
    output logic                fetch,
    output logic                opd,
    output mcpu_pkg::reg_upd_t  reg_upd,
    output logic [7:0]          psh_sel,
    output logic                hihalf,
    output logic                pul_en,
    output logic                psh_dec,
    output logic                wrq,
    output logic                stack_busy
);
    import mcpu_pkg::*;

    logic       step_en;
    uc_word_t   uc;
    logic [7:0] op_q;
    logic       stk_pull;
    logic       taken;

    // memory wait or missing enable freezes everything
    assign step_en = cen & ~mem_busy;
    assign opd     = uc.opd;

    // bit 6 tells lda from ldb
    assign reg_upd.a = uc.ld8 & ~op_q[6];
    assign reg_upd.b = uc.ld8 & op_q[6];
    assign reg_upd.d = uc.ld16 & (op_q == `MCPU_OP_LDD);
    assign reg_upd.x = uc.ld16 & (op_q == `MCPU_OP_LDX);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `MCPU_RESET_PC;
        end else if (step_en) begin
            if (fetch || uc.opd) begin
                pc <= pc + 16'd1;
            end else if (uc.br8 && taken) begin
                pc <= pc + {{8{mdata[7]}}, mdata[7:0]};
            end else if (uc.br16 && taken) begin
                pc <= pc + mdata;
            end else if (uc.jmp) begin
                pc <= mdata;
            end else if (pul_en && psh_sel[7]) begin
                // pc pulled one byte at a time, high byte first
                if (hihalf) begin
                    pc[15:8] <= mdata[7:0];
                end else begin
                    pc[7:0] <= mdata[7:0];
                end
            end
        end
    end

    mcpu_ucode u_ucode (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( step_en    ),
        .op         ( op         ),
        .stack_busy ( stack_busy ),
        .uc         ( uc         ),
        .fetch      ( fetch      ),
        .op_q       ( op_q       ),
        .stk_pull   ( stk_pull   )
    );

    mcpu_branch u_branch (
        .op_q  ( op_q  ),
        .cc    ( cc    ),
        .taken ( taken )
    );

    mcpu_pshpul u_pshpul (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .cen        ( step_en     ),
        .stk_go     ( uc.stk_go   ),
        .stk_pull   ( stk_pull    ),
        .postbyte   ( mdata[7:0]  ),
        .psh_sel    ( psh_sel     ),
        .hihalf     ( hihalf      ),
        .pul_en     ( pul_en      ),
        .psh_dec    ( psh_dec     ),
        .wrq        ( wrq         ),
        .stack_busy ( stack_busy  )
    );

endmodule

/* tb/mcpu_ctrl_tb.sv */
// testbench for the control section: stimulus table, reference model and checks
`include "mcpu_settings.svh"

module mcpu_ctrl_tb;
    import mcpu_pkg::*;

    localparam int FETCH_LIMIT = 64;
    localparam int RUN_LIMIT   = 256;

    typedef struct packed {
        logic [7:0]  op;
        logic [15:0] mdata;
        cc_t         cc;
        logic        gaps;
        logic [15:0] start_pc;
        logic [15:0] exp_pc;
        reg_upd_t    exp_upd;
        logic [1:0]  exp_upd_cnt;
        logic [1:0]  exp_opd;
        logic [4:0]  exp_xfer;
        logic [4:0]  exp_cycles;
    } row_t;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  op;
    logic [15:0] mdata;
    cc_t         cc;
    logic        mem_busy;
    logic [15:0] pc;
    logic        fetch;
    logic        opd;
    reg_upd_t    reg_upd;
    logic [7:0]  psh_sel;
    logic        hihalf;
    logic        pul_en;
    logic        psh_dec;
    logic        wrq;
    logic        stack_busy;

    row_t        tbl[$];
    // expected {psh_sel, hihalf} of each stack transfer
    logic [8:0]  xq[$];
    logic [15:0] model_pc;
    int          errors;
    int          checks;
    int          row_errs;
    int          rows_done;
    logic        timed_out;

    mcpu_ctrl u_dut (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .op         ( op         ),
        .mdata      ( mdata      ),
        .cc         ( cc         ),
        .mem_busy   ( mem_busy   ),
        .pc         ( pc         ),
        .fetch      ( fetch      ),
        .opd        ( opd        ),
        .reg_upd    ( reg_upd    ),
        .psh_sel    ( psh_sel    ),
        .hihalf     ( hihalf     ),
        .pul_en     ( pul_en     ),
        .psh_dec    ( psh_dec    ),
        .wrq        ( wrq        ),
        .stack_busy ( stack_busy )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errs++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // the sixteen 6809 conditions, one formula each
    function automatic logic branch_taken(input logic [3:0] cond, input cc_t f);
        logic c;
        logic v;
        logic z;
        logic n;
        logic t;
        c = f[`MCPU_CC_C];
        v = f[`MCPU_CC_V];
        z = f[`MCPU_CC_Z];
        n = f[`MCPU_CC_N];
        case (cond)
            4'h0: t = 1'b1;
            4'h1: t = 1'b0;
            4'h2: t = !(c || z);
            4'h3: t = c || z;
            4'h4: t = !c;
            4'h5: t = c;
            4'h6: t = !z;
            4'h7: t = z;
            4'h8: t = !v;
            4'h9: t = v;
            4'hA: t = !n;
            4'hB: t = n;
            4'hC: t = (n == v);
            4'hD: t = (n != v);
            4'hE: t = !z && (n == v);
            default: t = z || (n != v);
        endcase
        return t;
    endfunction

    // one byte per 8-bit register, two per 16-bit register
    function automatic logic [4:0] count_xfers(input logic [7:0] pb);
        logic [4:0] n;
        n = 5'd0;
        for (int i = 0; i < 8; i++) begin
            if (pb[i]) begin
                n = n + ((i >= 4) ? 5'd2 : 5'd1);
            end
        end
        return n;
    endfunction

    task automatic build_transfers(input logic [7:0] pb, input logic pull);
        int         i;
        int         k;
        logic [7:0] sel;
        xq.delete();
        for (k = 0; k < 8; k++) begin
            i = pull ? k : 7 - k;
            if (pb[i]) begin
                sel = 8'd1 << i;
                if (i >= 4) begin
                    xq.push_back({sel, pull});
                    xq.push_back({sel, ~pull});
                end else begin
                    xq.push_back({sel, 1'b0});
                end
            end
        end
    endtask

    task automatic add_row(input logic [7:0] o, input logic [15:0] md, input cc_t f,
                           input logic g);
        row_t       rw;
        logic [15:0] s;
        logic [4:0] n;
        rw          = '0;
        rw.op       = o;
        rw.mdata    = md;
        rw.cc       = f;
        rw.gaps     = g;
        rw.start_pc = model_pc;
        s           = model_pc;
        // nop and undefined opcodes
        rw.exp_pc     = s + 16'd1;
        rw.exp_cycles = 5'd1;
        case (o)
            `MCPU_OP_LDA, `MCPU_OP_LDB: begin
                rw.exp_pc      = s + 16'd2;
                rw.exp_cycles  = 5'd2;
                rw.exp_opd     = 2'd1;
                rw.exp_upd_cnt = 2'd1;
                rw.exp_upd.a   = (o == `MCPU_OP_LDA);
                rw.exp_upd.b   = (o == `MCPU_OP_LDB);
            end
            `MCPU_OP_LDD, `MCPU_OP_LDX: begin
                rw.exp_pc      = s + 16'd3;
                rw.exp_cycles  = 5'd3;
                rw.exp_opd     = 2'd2;
                rw.exp_upd_cnt = 2'd1;
                rw.exp_upd.d   = (o == `MCPU_OP_LDD);
                rw.exp_upd.x   = (o == `MCPU_OP_LDX);
            end
            `MCPU_OP_JMP: begin
                rw.exp_pc     = md;
                rw.exp_cycles = 5'd4;
                rw.exp_opd    = 2'd2;
            end
            `MCPU_OP_PSHS, `MCPU_OP_PULS: begin
                n             = count_xfers(md[7:0]);
                rw.exp_xfer   = n;
                rw.exp_cycles = 5'd3 + n;
                rw.exp_opd    = 2'd1;
                rw.exp_pc     = s + 16'd2;
                // both pc bytes come from the low byte of mdata
                if (o == `MCPU_OP_PULS && md[7]) begin
                    rw.exp_pc = {md[7:0], md[7:0]};
                end
            end
            default: begin
                if (o[7:4] == `MCPU_OP_BCC_ROW) begin
                    rw.exp_cycles = 5'd3;
                    rw.exp_opd    = 2'd1;
                    rw.exp_pc     = s + 16'd2;
                    if (branch_taken(o[3:0], f)) begin
                        rw.exp_pc = rw.exp_pc + {{8{md[7]}}, md[7:0]};
                    end
                end else if (o[7:4] == `MCPU_OP_LBCC_ROW) begin
                    rw.exp_cycles = 5'd4;
                    rw.exp_opd    = 2'd2;
                    rw.exp_pc     = s + 16'd3;
                    if (branch_taken(o[3:0], f)) begin
                        rw.exp_pc = rw.exp_pc + md;
                    end
                end
            end
        endcase
        // the trailing nop fetch moves pc on by one
        model_pc = rw.exp_pc + 16'd1;
        tbl.push_back(rw);
    endtask

    task automatic apply_gaps(input logic g);
        if (g) begin
            cen      = ($urandom % 5) != 0;
            mem_busy = ($urandom % 3) == 0;
        end else begin
            cen      = 1'b1;
            mem_busy = 1'b0;
        end
    endtask

    function automatic logic [8:0] strobe_bits();
        return {fetch, opd, reg_upd, wrq, psh_dec, pul_en};
    endfunction

    task automatic check_quiet();
        if (!cen || mem_busy) begin
            check_val("strobes in stalled cycle", 32'(strobe_bits()), 32'd0);
        end
    endtask

    task automatic run_row(input int r);
        row_t       rw;
        logic       got;
        int         t;
        int         cycles;
        int         upd_cnt;
        int         opd_cnt;
        int         busy_cnt;
        int         wrq_cnt;
        int         dec_cnt;
        int         pul_cnt;
        int         push_n;
        int         pull_n;
        logic [8:0] xp;
        rw       = tbl[r];
        row_errs = 0;
        cycles   = 1;
        upd_cnt  = 0;
        opd_cnt  = 0;
        busy_cnt = 0;
        wrq_cnt  = 0;
        dec_cnt  = 0;
        pul_cnt  = 0;
        op       = rw.op;
        mdata    = rw.mdata;
        cc       = rw.cc;
        build_transfers(rw.mdata[7:0], rw.op == `MCPU_OP_PULS);
        got = 1'b0;
        for (t = 0; t < FETCH_LIMIT && !got; t++) begin
            apply_gaps(rw.gaps);
            @(negedge clk);
            check_quiet();
            if (fetch) begin
                got = 1'b1;
                check_val("pc at fetch", 32'(pc), 32'(rw.start_pc));
                // a fetch cycle carries no other strobe
                check_val("strobes at fetch", 32'(strobe_bits()), 32'h100);
            end
            @(posedge clk);
            #5;
        end
        if (!got) begin
            $display("row %0d: no fetch seen within %0d cycles", r, FETCH_LIMIT);
            timed_out = 1'b1;
            return;
        end
        // the next fetch picks up a nop
        op  = `MCPU_OP_NOP;
        got = 1'b0;
        for (t = 0; t < RUN_LIMIT && !got; t++) begin
            apply_gaps(rw.gaps);
            @(negedge clk);
            check_quiet();
            if (fetch) begin
                got = 1'b1;
                check_val("pc at next fetch", 32'(pc), 32'(rw.exp_pc));
                check_val("strobes at next fetch", 32'(strobe_bits()), 32'h100);
            end else if (cen && !mem_busy) begin
                cycles++;
                if (reg_upd != '0) begin
                    upd_cnt++;
                    check_val("reg_upd", 32'(reg_upd), 32'(rw.exp_upd));
                end
                if (opd) opd_cnt++;
                if (stack_busy) busy_cnt++;
                if (wrq) wrq_cnt++;
                if (psh_dec) dec_cnt++;
                if (pul_en) pul_cnt++;
                if ((wrq || pul_en) && xq.size() > 0) begin
                    xp = xq.pop_front();
                    check_val("psh_sel", 32'(psh_sel), 32'(xp[8:1]));
                    check_val("hihalf", 32'(hihalf), 32'(xp[0]));
                end
            end
            @(posedge clk);
            #5;
        end
        if (!got) begin
            $display("row %0d: instruction did not finish within %0d cycles", r, RUN_LIMIT);
            timed_out = 1'b1;
            return;
        end
        push_n = (rw.op == `MCPU_OP_PSHS) ? 32'(rw.exp_xfer) : 0;
        pull_n = (rw.op == `MCPU_OP_PULS) ? 32'(rw.exp_xfer) : 0;
        check_val("update strobe count", upd_cnt, 32'(rw.exp_upd_cnt));
        check_val("opd count", opd_cnt, 32'(rw.exp_opd));
        check_val("stack_busy cycles", busy_cnt, 32'(rw.exp_xfer));
        check_val("wrq count", wrq_cnt, push_n);
        check_val("psh_dec count", dec_cnt, push_n);
        check_val("pul_en count", pul_cnt, pull_n);
        if (!rw.gaps) begin
            check_val("cycle count", cycles, 32'(rw.exp_cycles));
        end
        rows_done++;
        $display("row %0d op %h mdata %h gaps %0d: %0d mismatches",
                 r, rw.op, rw.mdata, rw.gaps, row_errs);
    endtask

    initial begin
        cc_t rcc;
        int  k;
        void'($urandom(45679));
        rst       = 1'b1;
        cen       = 1'b0;
        op        = `MCPU_OP_NOP;
        mdata     = 16'h0000;
        cc        = '0;
        mem_busy  = 1'b0;
        errors    = 0;
        checks    = 0;
        rows_done = 0;
        timed_out = 1'b0;
        model_pc  = `MCPU_RESET_PC;

        add_row(`MCPU_OP_NOP, 16'h0000, '0, 1'b0);
        add_row(8'h01, 16'h0000, '0, 1'b0);
        add_row(`MCPU_OP_LDA, 16'h0042, '0, 1'b0);
        add_row(`MCPU_OP_LDB, 16'h00A5, '0, 1'b0);
        add_row(`MCPU_OP_LDD, 16'h1234, '0, 1'b0);
        add_row(`MCPU_OP_LDX, 16'hBEEF, '0, 1'b0);
        // two passes over the short branches, forward then backward
        for (k = 0; k < 32; k++) begin
            rcc = 8'($urandom);
            add_row({`MCPU_OP_BCC_ROW, 4'(k)}, (k < 16) ? 16'h0012 : 16'h00EA, rcc, 1'b0);
        end
        add_row({`MCPU_OP_LBCC_ROW, 4'h0}, 16'h0300, '0, 1'b0);
        add_row({`MCPU_OP_LBCC_ROW, 4'h1}, 16'h0200, '0, 1'b0);
        rcc = 8'($urandom);
        add_row({`MCPU_OP_LBCC_ROW, 4'h7}, 16'hFF00, rcc, 1'b0);
        rcc = 8'($urandom);
        add_row({`MCPU_OP_LBCC_ROW, 4'hC}, 16'h0040, rcc, 1'b0);
        add_row(`MCPU_OP_JMP, 16'h4000, '0, 1'b0);
        add_row(`MCPU_OP_JMP, 16'h0100, '0, 1'b0);
        add_row(`MCPU_OP_PSHS, 16'h00FF, '0, 1'b0);
        add_row(`MCPU_OP_PSHS, 16'h0000, '0, 1'b0);
        add_row(`MCPU_OP_PSHS, 16'h0086, '0, 1'b0);
        add_row(`MCPU_OP_PULS, 16'h0013, '0, 1'b0);
        add_row(`MCPU_OP_PULS, 16'h0000, '0, 1'b0);
        add_row(`MCPU_OP_PULS, 16'h0096, '0, 1'b0);
        add_row(`MCPU_OP_PULS, 16'h00C1, '0, 1'b0);
        // same kinds of rows with cen and mem_busy gaps
        add_row(`MCPU_OP_LDA, 16'h0011, '0, 1'b1);
        add_row(`MCPU_OP_LDX, 16'h2222, '0, 1'b1);
        rcc = 8'($urandom);
        add_row(8'h26, 16'h0008, rcc, 1'b1);
        rcc = 8'($urandom);
        add_row(8'h5E, 16'h0123, rcc, 1'b1);
        add_row(`MCPU_OP_JMP, 16'h0800, '0, 1'b1);
        add_row(`MCPU_OP_PSHS, 16'h00F1, '0, 1'b1);
        add_row(`MCPU_OP_PULS, 16'h00C3, '0, 1'b1);
        add_row(`MCPU_OP_LDB, 16'h005A, '0, 1'b1);

        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        // one idle cycle with cen low before the first fetch
        @(negedge clk);
        row_errs = 0;
        check_val("pc after reset", 32'(pc), 32'(`MCPU_RESET_PC));
        check_val("strobes after reset", 32'(strobe_bits()), 32'd0);
        check_val("stack_busy after reset", 32'(stack_busy), 32'd0);
        $display("reset: %0d mismatches", row_errs);
        @(posedge clk);
        #5;

        for (k = 0; k < tbl.size() && !timed_out; k++) begin
            run_row(k);
        end

        $display("rows %0d of %0d, checks %0d, errors %0d",
                 rows_done, tbl.size(), checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
src/mcpu_pkg.sv
src/mcpu_branch.sv
src/mcpu_pshpul.sv
src/mcpu_ucode.sv
src/mcpu_ctrl.sv
tb/mcpu_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the control section testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=mcpu_sim

verilator --binary --timing -f build.f --top-module mcpu_ctrl_tb -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "run_sim: simulation ok"
    exit 0
else
    echo "run_sim: simulation reported failure, see $LOG"
    exit 1
fi
